/* design/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// processor side
`define CACHE_WORD_W      32
`define CACHE_ADDR_W      30

// memory side
`define CACHE_LINE_W      128
`define CACHE_MEM_ADDR_W  28

// line geometry
`define CACHE_WORDS       4
`define CACHE_OFFSET_W    2
`define CACHE_LINES       8
`define CACHE_INDEX_W     3
`define CACHE_TAG_W       25

// controller states
`define CACHE_ST_JUDGE    3'd0
`define CACHE_ST_WB       3'd1
`define CACHE_ST_MISS     3'd2
`define CACHE_ST_HIT      3'd3
`define CACHE_ST_SHOW     3'd4
`define CACHE_ST_STALL    3'd5

`endif

/* design/cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

    // one line, seen by memory as a single word and by the processor as four
    // word 0 sits in the low bits
    typedef union packed {
        logic [`CACHE_LINE_W-1:0]                   flat;
        logic [`CACHE_WORDS-1:0][`CACHE_WORD_W-1:0] words;
    } cache_line_u;

endpackage

/* design/cache_store_if.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

interface cache_store_if
    import cache_pkg::*;
();

    // request fields, from the controller
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_WORD_W-1:0]   wdata;
    logic                       word_wr;
    logic                       fill;
    cache_line_u                fill_line;

    // lookup results for the indexed line
    logic                       hit;
    logic                       dirty;
    logic [`CACHE_TAG_W-1:0]    victim_tag;
    cache_line_u                line;

    modport ctrl (
        output index, tag, offset, wdata, word_wr, fill, fill_line,
        input  hit, dirty, victim_tag, line
    );

    modport store (
        input  index, tag, offset, wdata, word_wr, fill, fill_line,
        output hit, dirty, victim_tag, line
    );

endinterface

/* design/cache_ctrl.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         proc_reset,
    input  logic                         proc_read,
    input  logic                         proc_write,
    input  logic [`CACHE_ADDR_W-1:0]     proc_addr,
    input  logic [`CACHE_WORD_W-1:0]     proc_wdata,
    input  logic [`CACHE_LINE_W-1:0]     mem_rdata,
    input  logic                         mem_ready,
    output logic                         proc_stall,
    output logic [`CACHE_WORD_W-1:0]     proc_rdata,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [`CACHE_MEM_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_LINE_W-1:0]     mem_wdata,
    cache_store_if.ctrl                  st
);

    logic                         proc_read_r;
    logic                         proc_write_r;
    logic [`CACHE_ADDR_W-1:0]     proc_addr_r;
    logic [`CACHE_WORD_W-1:0]     proc_wdata_r;
    logic                         mem_ready_r;
    logic                         mem_ready_q;
    cache_line_u                  mem_line_r;

    logic [2:0]                   state;
    logic [2:0]                   state_next;
    logic                         proc_stall_next;
    logic [`CACHE_WORD_W-1:0]     proc_rdata_next;
    logic                         mem_read_next;
    logic                         mem_write_next;
    logic [`CACHE_MEM_ADDR_W-1:0] mem_addr_next;
    logic [`CACHE_LINE_W-1:0]     mem_wdata_next;

    logic                         req;
    logic                         mem_ack;
    logic [`CACHE_MEM_ADDR_W-1:0] line_addr;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            proc_read_r  <= 1'b0;
            proc_write_r <= 1'b0;
            mem_ready_r  <= 1'b0;
            mem_ready_q  <= 1'b0;
        end else begin
            proc_read_r  <= proc_read;
            proc_write_r <= proc_write;
            mem_ready_r  <= mem_ready;
            mem_ready_q  <= mem_ready_r;
        end
    end

    always_ff @(posedge clk) begin
        proc_addr_r     <= proc_addr;
        proc_wdata_r    <= proc_wdata;
        mem_line_r.flat <= mem_rdata;
    end

    assign req = proc_read_r | proc_write_r;
    // ready counts on its rising edge, so a held ready is taken once
    assign mem_ack = mem_ready_r & ~mem_ready_q;
    assign line_addr = proc_addr_r[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

    assign st.offset    = proc_addr_r[`CACHE_OFFSET_W-1:0];
    assign st.index     = proc_addr_r[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign st.tag       = proc_addr_r[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign st.wdata     = proc_wdata_r;
    assign st.fill_line = mem_line_r;
    assign st.fill      = (state == `CACHE_ST_MISS) && mem_ack;
    assign st.word_wr   = (state == `CACHE_ST_HIT) && proc_write_r;

    always_comb begin
        state_next      = state;
        proc_stall_next = 1'b1;
        proc_rdata_next = proc_rdata;
        mem_read_next   = mem_read;
        mem_write_next  = mem_write;
        mem_addr_next   = mem_addr;
        mem_wdata_next  = mem_wdata;
        case (state)
            `CACHE_ST_JUDGE: begin
                if (req) begin
                    if (st.hit) begin
                        state_next = `CACHE_ST_HIT;
                    end else if (st.dirty) begin
                        // victim goes out first
                        state_next     = `CACHE_ST_WB;
                        mem_write_next = 1'b1;
                        mem_addr_next  = {st.victim_tag, st.index};
                        mem_wdata_next = st.line.flat;
                    end else begin
                        state_next    = `CACHE_ST_MISS;
                        mem_read_next = 1'b1;
                        mem_addr_next = line_addr;
                    end
                end
            end
            `CACHE_ST_WB: begin
                if (mem_ack) begin
                    state_next     = `CACHE_ST_MISS;
                    mem_write_next = 1'b0;
                    mem_read_next  = 1'b1;
                    mem_addr_next  = line_addr;
                end
            end
            `CACHE_ST_MISS: begin
                if (mem_ack) begin
                    state_next    = `CACHE_ST_HIT;
                    mem_read_next = 1'b0;
                end
            end
            `CACHE_ST_HIT: begin
                state_next      = `CACHE_ST_SHOW;
                proc_stall_next = 1'b0;
                if (proc_read_r) begin
                    proc_rdata_next = st.line.words[st.offset];
                end
            end
            `CACHE_ST_SHOW: begin
                state_next = `CACHE_ST_STALL;
            end
            `CACHE_ST_STALL: begin
                // lets the input registers pick up the next request
                state_next = `CACHE_ST_JUDGE;
            end
            default: begin
                state_next     = `CACHE_ST_JUDGE;
                mem_read_next  = 1'b0;
                mem_write_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state      <= `CACHE_ST_JUDGE;
            proc_stall <= 1'b1;
            proc_rdata <= '0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            mem_addr   <= '0;
            mem_wdata  <= '0;
        end else begin
            state      <= state_next;
            proc_stall <= proc_stall_next;
            proc_rdata <= proc_rdata_next;
            mem_read   <= mem_read_next;
            mem_write  <= mem_write_next;
            mem_addr   <= mem_addr_next;
            mem_wdata  <= mem_wdata_next;
        end
    end

endmodule

/* design/cache_store.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_store
    import cache_pkg::*;
(
    input  logic          clk,
    input  logic          proc_reset,
    cache_store_if.store  st
);

    cache_line_u               line_mem [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]   tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]   valid;
    logic [`CACHE_LINES-1:0]   dirty;

    // one-hot line select
    logic [`CACHE_LINES-1:0]   line_sel;

    // read side
    cache_line_u               rd_line;
    logic [`CACHE_TAG_W-1:0]   rd_tag;

    always_comb begin
        line_sel = '0;
        line_sel[st.index] = 1'b1;
    end

    always_comb begin
        rd_line = '0;
        rd_tag  = '0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            if (line_sel[i]) begin
                rd_line = line_mem[i];
                rd_tag  = tag_mem[i];
            end
        end
    end

    assign st.line       = rd_line;
    assign st.victim_tag = rd_tag;
    assign st.dirty      = |(dirty & line_sel);
    assign st.hit        = |(valid & line_sel) && (rd_tag == st.tag);

    // fill replaces the whole line, a word write touches one word
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CACHE_LINES; i++) begin
            if (line_sel[i]) begin
                if (st.fill) begin
                    line_mem[i].flat <= st.fill_line.flat;
                    tag_mem[i]       <= st.tag;
                end else if (st.word_wr) begin
                    line_mem[i].words[st.offset] <= st.wdata;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                if (line_sel[i]) begin
                    if (st.fill) begin
                        valid[i] <= 1'b1;
                        dirty[i] <= 1'b0;
                    end else if (st.word_wr) begin
                        dirty[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* design/cache.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache (
    input  logic                         clk,
    input  logic                         proc_reset,

    // processor side
    input  logic                         proc_read,
    input  logic                         proc_write,
    input  logic [`CACHE_ADDR_W-1:0]     proc_addr,
    input  logic [`CACHE_WORD_W-1:0]     proc_wdata,
    output logic                         proc_stall,
    output logic [`CACHE_WORD_W-1:0]     proc_rdata,

    // memory side
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [`CACHE_MEM_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_LINE_W-1:0]     mem_wdata,
    input  logic [`CACHE_LINE_W-1:0]     mem_rdata,
    input  logic                         mem_ready
);

    cache_store_if st_if ();

    cache_ctrl cache_ctrl_u (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .st         (st_if.ctrl)
    );

    cache_store cache_store_u (
        .clk        (clk),
        .proc_reset (proc_reset),
        .st         (st_if.store)
    );

endmodule

/* sim/cache_sva.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_sva (
    input  logic                         clk,
    input  logic                         proc_reset,
    input  logic                         proc_stall,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic                         mem_ready,
    input  logic [`CACHE_MEM_ADDR_W-1:0] mem_addr,
    input  logic [`CACHE_LINE_W-1:0]     mem_wdata
);

    int fail_cnt = 0;

    // one memory request kind at a time
    no_rd_wr: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write high together");
        fail_cnt++;
    end

    // request held steady until memory answers
    req_stable: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata))
    else begin
        $error("mem_addr or mem_wdata changed while waiting for mem_ready");
        fail_cnt++;
    end

    // result shown for a single cycle only
    stall_pulse: assert property (@(posedge clk) disable iff (proc_reset)
        !proc_stall |=> proc_stall)
    else begin
        $error("proc_stall low in two consecutive cycles");
        fail_cnt++;
    end

    // first clocked cycle out of reset stays idle
    reset_idle: assert property (@(posedge clk)
        $fell(proc_reset) |=> proc_stall && !mem_read && !mem_write)
    else begin
        $error("outputs not idle after reset release");
        fail_cnt++;
    end

endmodule

bind cache_ctrl cache_sva cache_sva_u (.*);

/* sim/cache_tb.sv */
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int          CLK_PERIOD = 40;
    localparam int          NUM_REQS   = 211;
    localparam logic [31:0] FILL_K     = 32'h9E37_79B1;
    localparam logic [29:0] ADDR_A     = 30'h0012_3456;
    localparam logic [29:0] ADDR_B     = 30'h0012_3476;
    localparam logic [29:0] ADDR_C     = 30'h0004_5678;

    logic                         clk;
    logic                         proc_reset;
    logic                         proc_read;
    logic                         proc_write;
    logic [`CACHE_ADDR_W-1:0]     proc_addr;
    logic [`CACHE_WORD_W-1:0]     proc_wdata;
    logic                         proc_stall;
    logic [`CACHE_WORD_W-1:0]     proc_rdata;
    logic                         mem_read;
    logic                         mem_write;
    logic [`CACHE_MEM_ADDR_W-1:0] mem_addr;
    logic [`CACHE_LINE_W-1:0]     mem_wdata;
    logic [`CACHE_LINE_W-1:0]     mem_rdata;
    logic                         mem_ready;

    // sparse backing memory and expected word values
    logic [`CACHE_LINE_W-1:0]     mem_arr [logic [`CACHE_MEM_ADDR_W-1:0]];
    logic [`CACHE_WORD_W-1:0]     ref_arr [logic [`CACHE_ADDR_W-1:0]];

    logic [31:0]                  lcg_state = 32'd59460;
    int                           mem_rd_cnt = 0;
    int                           mem_wr_cnt = 0;
    logic [`CACHE_MEM_ADDR_W-1:0] last_rd_addr = '0;
    logic [`CACHE_MEM_ADDR_W-1:0] last_wr_addr = '0;
    cache_line_u                  last_wr_line = '0;
    int                           test_errs = 0;
    int                           tests_ok = 0;
    int                           tests_bad = 0;
    int                           sva_seen = 0;

    cache cache_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`CACHE_WORD_W-1:0] init_word(input logic [29:0] a);
        return {2'b00, a} * FILL_K;
    endfunction

    function automatic logic [`CACHE_WORD_W-1:0] expected(input logic [29:0] a);
        if (ref_arr.exists(a)) begin
            return ref_arr[a];
        end
        return init_word(a);
    endfunction

    function automatic cache_line_u mem_line(input logic [27:0] la);
        cache_line_u l;
        if (mem_arr.exists(la)) begin
            l.flat = mem_arr[la];
        end else begin
            for (int w = 0; w < `CACHE_WORDS; w++) begin
                l.words[w[1:0]] = init_word({la, w[1:0]});
            end
        end
        return l;
    endfunction

    // memory answers each request after 1 to 4 cycles, holds ready for two
    initial begin : mem_model
        logic [31:0]  r;
        logic [27:0]  la;
        cache_line_u  l;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #5;
            if (mem_read || mem_write) begin
                la = mem_addr;
                r = lcg_next();
                repeat ({1'b0, r[17:16]} + 3'd1) begin
                    @(posedge clk);
                end
                #5;
                if (mem_write) begin
                    mem_arr[la] = mem_wdata;
                    mem_wr_cnt++;
                    last_wr_addr = la;
                    last_wr_line.flat = mem_wdata;
                end else begin
                    l = mem_line(la);
                    mem_rdata = l.flat;
                    mem_rd_cnt++;
                    last_rd_addr = la;
                end
                mem_ready = 1'b1;
                repeat (2) @(posedge clk);
                #5;
                mem_ready = 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("ERR %s: expected %h got %h", name, exp, got);
            test_errs++;
        end
    endtask

    // holds the request until proc_stall is seen low
    task automatic access(input logic wr, input logic [29:0] a, input logic [31:0] d,
                          output logic [31:0] rd);
        proc_read = ~wr;
        proc_write = wr;
        proc_addr = a;
        proc_wdata = d;
        do begin
            @(negedge clk);
        end while (proc_stall);
        rd = proc_rdata;
        @(posedge clk);
        #5;
        proc_read = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic read_check(input logic [29:0] a);
        logic [31:0] rd;
        access(1'b0, a, 32'h0, rd);
        check_value("proc_rdata", expected(a), rd);
    endtask

    task automatic write_word(input logic [29:0] a, input logic [31:0] d);
        logic [31:0] rd;
        access(1'b1, a, d, rd);
        ref_arr[a] = d;
    endtask

    task automatic end_test(input string name);
        int sva_now;
        sva_now = cache_inst.cache_ctrl_u.cache_sva_u.fail_cnt;
        if (sva_now != sva_seen) begin
            $display("protocol assertion failed during %s", name);
            test_errs++;
            sva_seen = sva_now;
        end
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin : watchdog
        repeat (NUM_REQS * 400 + 16) @(posedge clk);
        $display("timeout: requests did not finish within %0d cycles", NUM_REQS * 400);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [29:0] a;
        int          rd0;
        int          wr0;
        proc_reset = 1'b1;
        proc_read = 1'b0;
        proc_write = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        repeat (16) @(posedge clk);
        #5;
        proc_reset = 1'b0;
        @(posedge clk);
        #5;

        rd0 = mem_rd_cnt;
        read_check(ADDR_A);
        check_value("mem_read count", rd0 + 1, mem_rd_cnt);
        check_value("mem_addr", {4'h0, ADDR_A[29:2]}, {4'h0, last_rd_addr});
        end_test("cold read miss");

        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        read_check({ADDR_A[29:2], 2'd0});
        read_check({ADDR_A[29:2], 2'd1});
        read_check({ADDR_A[29:2], 2'd3});
        check_value("mem_read count", rd0, mem_rd_cnt);
        check_value("mem_write count", wr0, mem_wr_cnt);
        end_test("read hit after fill");

        wr0 = mem_wr_cnt;
        write_word(ADDR_A, 32'hCAFE_F00D);
        read_check(ADDR_A);
        check_value("mem_write count", wr0, mem_wr_cnt);
        end_test("write hit then read");

        // same index, other tag, so the dirty line goes out first
        wr0 = mem_wr_cnt;
        read_check(ADDR_B);
        check_value("mem_write count", wr0 + 1, mem_wr_cnt);
        check_value("mem_addr", {4'h0, ADDR_A[29:2]}, {4'h0, last_wr_addr});
        check_value("mem_wdata", 32'hCAFE_F00D, last_wr_line.words[ADDR_A[1:0]]);
        read_check(ADDR_A);
        end_test("dirty eviction");

        rd0 = mem_rd_cnt;
        write_word(ADDR_C, 32'h1357_9BDF);
        check_value("mem_read count", rd0 + 1, mem_rd_cnt);
        read_check(ADDR_C);
        read_check(ADDR_C ^ 30'h1);
        end_test("write miss allocate");

        // 64 words over 16 lines, two tags per index
        repeat (200) begin
            r = lcg_next();
            a = {24'd0, r[21:16]};
            if (r[8]) begin
                write_word(a, lcg_next());
            end else begin
                read_check(a);
            end
        end
        end_test("random mix");

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* cache.f */
+incdir+design
design/cache_pkg.sv
design/cache_store_if.sv
design/cache_ctrl.sv
design/cache_store.sv
design/cache.sv
sim/cache_sva.sv
sim/cache_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing --assert
TOP       := cache_tb
FILELIST  := cache.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
